/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_frame_buffer
FILELIST   := filelist.f
VFLAGS     := --binary --timing --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
source/fb_pkg.sv
source/pixel_writer.sv
source/pingpong_buffer.sv
source/row_reader.sv
source/fb_ctrl_axil.sv
source/frame_buffer_top.sv
sim/row_checker.sv
sim/tb_frame_buffer.sv

/* sim/row_checker.sv */
`timescale 1ns/100ps

module row_checker (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     count_reset,
    input logic                     row_valid,
    input logic                     row_ready,
    input logic [fb_pkg::ROW_W-1:0] row_data,
    input logic [fb_pkg::IDX_W-1:0] row_index,
    input logic                     row_last
);

    import fb_pkg::*;

    string            test_name    = "none";
    int               frame_no     = 0;           // frames fully received
    int               row_no       = 0;
    int               rows_checked = 0;
    int               error_count  = 0;
    logic             stalled      = 1'b0;
    logic [ROW_W-1:0] held_data;
    logic [IDX_W-1:0] held_index;
    logic             held_last;

    function automatic logic [PIX_W-1:0] pattern(input int frame, input int row, input int col);
        return PIX_W'((frame * 29 + row * 7 + col * 13 + 3) % 256);
    endfunction

    function automatic logic [ROW_W-1:0] expected_row(input int frame, input int row);
        logic [ROW_W-1:0] r;
        r = '0;
        for (int c = 0; c < FRAME_DIM; c++) begin
            r[ROW_W-1-c*PIX_W -: PIX_W] = pattern(frame, row, c); // column 0 on top
        end
        return r;
    endfunction

    task automatic check_row();
        logic [ROW_W-1:0] exp_data;
        exp_data = expected_row(frame_no, row_no);
        if (row_data !== exp_data) begin
            error_count++;
            $display("mismatch %s: frame %0d row %0d data expected %h actual %h",
                     test_name, frame_no, row_no, exp_data, row_data);
        end
        if (row_index !== IDX_W'(row_no)) begin
            error_count++;
            $display("mismatch %s: row_index expected %0d actual %0d",
                     test_name, row_no, row_index);
        end
        if (row_last !== (row_no == FRAME_DIM - 1)) begin
            error_count++;
            $display("mismatch %s: row_last at row %0d expected %b actual %b",
                     test_name, row_no, (row_no == FRAME_DIM - 1), row_last);
        end
        rows_checked++;
        if (row_no == FRAME_DIM - 1) begin
            row_no = 0;
            frame_no++;
        end else begin
            row_no++;
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            stalled = 1'b0;
        end else begin
            if (stalled && !row_valid) begin
                error_count++;
                $display("row_valid dropped during a stall in %s", test_name);
            end else if (stalled && (row_data !== held_data || row_index !== held_index ||
                                     row_last !== held_last)) begin
                error_count++;
                $display("row outputs changed while stalled in %s", test_name);
            end
            if (row_valid && row_ready) begin
                check_row();
            end
            stalled    = row_valid && !row_ready;
            held_data  = row_data;
            held_index = row_index;
            held_last  = row_last;
            if (count_reset) begin
                frame_no = 0;                        // back to pattern frame 0
                row_no   = 0;
            end
        end
    end

endmodule

/* sim/tb_frame_buffer.sv */
`timescale 1ns/100ps

module tb_frame_buffer;

    import fb_pkg::*;

    localparam int SEED           = 25257;
    localparam int CLK_PERIOD     = 8;
    localparam int PARTIAL_PIXELS = 500;
    localparam int TOTAL_PIXELS   = 10 * FRAME_DIM * FRAME_DIM + PARTIAL_PIXELS; // 10 frames
    localparam int TIMEOUT_NS     = CLK_PERIOD * 4 * TOTAL_PIXELS + 10000;

    logic                   clk;
    logic                   arst_n;
    logic                   pix_valid;
    logic                   pix_ready;
    logic [PIX_W-1:0]       pix_data;
    logic                   row_valid;
    logic                   row_ready;
    logic [ROW_W-1:0]       row_data;
    logic [IDX_W-1:0]       row_index;
    logic                   row_last;
    logic [AXIL_ADDR_W-1:0] s_awaddr;
    logic                   s_awvalid;
    logic                   s_awready;
    logic [AXIL_DATA_W-1:0] s_wdata;
    logic                   s_wvalid;
    logic                   s_wready;
    logic [1:0]             s_bresp;
    logic                   s_bvalid;
    logic                   s_bready;
    logic [AXIL_ADDR_W-1:0] s_araddr;
    logic                   s_arvalid;
    logic                   s_arready;
    logic [AXIL_DATA_W-1:0] s_rdata;
    logic [1:0]             s_rresp;
    logic                   s_rvalid;
    logic                   s_rready;
    logic                   count_reset;

    int                     ready_mode;           // 0 ready, 1 random, 2 held low
    int                     frames_in_cnt;
    int                     reg_errors;
    string                  test_name;
    logic [AXIL_DATA_W-1:0] rd_value;

    frame_buffer_top i_frame_buffer_top (.*);

    row_checker u_row_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        row_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            case (ready_mode)
                0:       row_ready = 1'b1;
                1:       row_ready = ($urandom % 3) != 0;
                default: row_ready = 1'b0;
            endcase
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the run did not complete", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [AXIL_DATA_W-1:0] status_expect(input int n_in, input int n_out);
        logic [AXIL_DATA_W-1:0] s;
        s = '0;
        for (int k = 0; k < n_in - n_out; k++) begin
            s[(n_out + k) % 2] = 1'b1;               // unread frames sit in order
        end
        s[2] = 1'(n_in % 2);
        s[3] = 1'(n_out % 2);
        return s;
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        u_row_checker.test_name = name;
        $display("-- %s", name);
    endtask

    task automatic send_pixels(input int frame, input int count, input bit gappy);
        for (int i = 0; i < count; i++) begin
            if (gappy && ($urandom % 4) == 0) begin
                pix_valid = 1'b0;
                repeat (($urandom % 3) + 1) @(posedge clk);
                #1;
            end
            pix_valid = 1'b1;
            pix_data  = u_row_checker.pattern(frame, i / FRAME_DIM, i % FRAME_DIM);
            do @(negedge clk); while (!pix_ready);
            @(posedge clk);
            #1;
        end
        pix_valid = 1'b0;
    endtask

    task automatic send_frame(input bit gappy);
        send_pixels(frames_in_cnt, FRAME_DIM * FRAME_DIM, gappy);
        frames_in_cnt++;
    endtask

    task automatic wait_frames(input int n);
        while (u_row_checker.frame_no < n) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [AXIL_ADDR_W-1:0] addr,
                             input logic [AXIL_DATA_W-1:0] data, input logic [1:0] exp_resp);
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;
        do @(negedge clk); while (!(s_awready && s_wready));
        @(posedge clk);
        #1;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        do @(negedge clk); while (!s_bvalid);
        if (s_bresp !== exp_resp) begin
            reg_errors++;
            $display("mismatch %s: bresp at %h expected %b actual %b",
                     test_name, addr, exp_resp, s_bresp);
        end
        @(posedge clk);
        #1;
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXIL_ADDR_W-1:0] addr, input logic [1:0] exp_resp,
                            output logic [AXIL_DATA_W-1:0] data);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b1;
        do @(negedge clk); while (!s_arready);
        @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        do @(negedge clk); while (!s_rvalid);
        data = s_rdata;
        if (s_rresp !== exp_resp) begin
            reg_errors++;
            $display("mismatch %s: rresp at %h expected %b actual %b",
                     test_name, addr, exp_resp, s_rresp);
        end
        @(posedge clk);
        #1;
        s_rready = 1'b0;
    endtask

    task automatic check_reg(input logic [AXIL_ADDR_W-1:0] addr,
                             input logic [AXIL_DATA_W-1:0] expected);
        logic [AXIL_DATA_W-1:0] value;
        axi_read(addr, RESP_OKAY, value);
        if (value !== expected) begin
            reg_errors++;
            $display("mismatch %s: register %h expected %h actual %h",
                     test_name, addr, expected, value);
        end
    endtask

    task automatic expect_no_ready(input int cycles);
        pix_valid = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (pix_ready !== 1'b0) begin
                reg_errors++;
                $display("pix_ready high in %s although pixel input should be blocked",
                         test_name);
            end
        end
        @(posedge clk);
        #1;
        pix_valid = 1'b0;
    endtask

    task automatic pulse_count_reset();
        count_reset = 1'b1;
        @(posedge clk);
        #1;
        count_reset = 1'b0;
    endtask

    initial begin
        arst_n        = 1'b0;
        pix_valid     = 1'b0;
        pix_data      = '0;
        count_reset   = 1'b0;
        s_awaddr      = '0;
        s_awvalid     = 1'b0;
        s_wdata       = '0;
        s_wvalid      = 1'b0;
        s_bready      = 1'b0;
        s_araddr      = '0;
        s_arvalid     = 1'b0;
        s_rready      = 1'b0;
        ready_mode    = 0;
        frames_in_cnt = 0;
        reg_errors    = 0;
        test_name     = "reset";
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        begin_test("single_frame");
        axi_write(REG_CTRL, 32'h1, RESP_OKAY);
        send_frame(1'b0);
        wait_frames(1);

        begin_test("random_stream");
        ready_mode = 1;
        repeat (5) send_frame(1'b1);
        wait_frames(6);

        begin_test("pingpong_full");
        ready_mode = 2;
        send_frame(1'b0);
        send_frame(1'b0);
        expect_no_ready(8);
        check_reg(REG_STATUS, status_expect(frames_in_cnt, u_row_checker.frame_no));
        ready_mode = 0;
        wait_frames(8);

        begin_test("registers");
        check_reg(REG_FRAMES_IN, frames_in_cnt);
        check_reg(REG_FRAMES_OUT, u_row_checker.frame_no);
        check_reg(REG_STATUS, status_expect(frames_in_cnt, u_row_checker.frame_no));
        axi_write(REG_CTRL, 32'h0, RESP_OKAY);
        check_reg(REG_CTRL, 32'h0);
        expect_no_ready(20);
        axi_write(REG_STATUS, 32'hF, RESP_OKAY);  // read only register
        axi_write(4'h6, 32'h1, RESP_SLVERR);
        axi_read(4'h2, RESP_SLVERR, rd_value);
        if (rd_value !== '0) begin
            reg_errors++;
            $display("mismatch %s: unmapped read expected %h actual %h", test_name, 0, rd_value);
        end

        begin_test("clear");
        axi_write(REG_CTRL, 32'h1, RESP_OKAY);
        send_frame(1'b0);                         // odd frame count moves both bank pointers
        wait_frames(9);
        send_pixels(frames_in_cnt, PARTIAL_PIXELS, 1'b1);   // partial frame to be thrown away
        axi_write(REG_CTRL, 32'h3, RESP_OKAY);
        pulse_count_reset();
        frames_in_cnt = 0;
        check_reg(REG_FRAMES_IN, 32'h0);
        check_reg(REG_FRAMES_OUT, 32'h0);
        check_reg(REG_STATUS, 32'h0);
        check_reg(REG_CTRL, 32'h1);
        send_frame(1'b0);
        wait_frames(1);
        check_reg(REG_FRAMES_IN, 32'h1);
        check_reg(REG_FRAMES_OUT, 32'h1);

        repeat (5) @(posedge clk);
        $display("errors: %0d row, %0d register; rows checked %0d",
                 u_row_checker.error_count, reg_errors, u_row_checker.rows_checked);
        if (u_row_checker.error_count == 0 && reg_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* source/fb_ctrl_axil.sv */
`timescale 1ns/100ps

module fb_ctrl_axil (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [fb_pkg::AXIL_ADDR_W-1:0] s_awaddr,
    input  logic                           s_awvalid,
    output logic                           s_awready,
    input  logic [fb_pkg::AXIL_DATA_W-1:0] s_wdata,
    input  logic                           s_wvalid,
    output logic                           s_wready,
    output logic [1:0]                     s_bresp,
    output logic                           s_bvalid,
    input  logic                           s_bready,
    input  logic [fb_pkg::AXIL_ADDR_W-1:0] s_araddr,
    input  logic                           s_arvalid,
    output logic                           s_arready,
    output logic [fb_pkg::AXIL_DATA_W-1:0] s_rdata,
    output logic [1:0]                     s_rresp,
    output logic                           s_rvalid,
    input  logic                           s_rready,
    input  logic [1:0]                     bank_full,
    input  logic                           wr_bank,
    input  logic                           rd_bank,
    input  logic                           frame_in_pulse,
    input  logic                           frame_out_pulse,
    output logic                           enable,
    output logic                           clear_pulse
);

    import fb_pkg::*;

    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_hit;
    logic                   rd_hit;
    logic [AXIL_DATA_W-1:0] rd_value;
    logic [AXIL_DATA_W-1:0] status_word;
    logic [CNT_W-1:0]       frames_in_q;
    logic [CNT_W-1:0]       frames_out_q;

    // aw and w taken as a pair, one write in flight
    assign wr_fire   = s_awvalid & s_wvalid & ~s_bvalid;
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;

    assign rd_fire   = s_arvalid & ~s_rvalid;
    assign s_arready = ~s_rvalid;

    assign wr_hit = (s_awaddr == REG_CTRL) || (s_awaddr == REG_STATUS) ||
                    (s_awaddr == REG_FRAMES_IN) || (s_awaddr == REG_FRAMES_OUT);

    always_comb begin
        status_word                              = '0;
        status_word[STAT_FULL_LSB +: 2]          = bank_full;
        status_word[STAT_WR_BANK]                = wr_bank;
        status_word[STAT_RD_BANK]                = rd_bank;
    end

    always_comb begin
        rd_hit   = 1'b1;
        rd_value = '0;
        case (s_araddr)
            REG_CTRL:       rd_value[CTRL_EN_BIT] = enable; // clear reads back 0
            REG_STATUS:     rd_value = status_word;
            REG_FRAMES_IN:  rd_value = frames_in_q;
            REG_FRAMES_OUT: rd_value = frames_out_q;
            default:        rd_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_bvalid    <= 1'b0;
            s_bresp     <= RESP_OKAY;
            enable      <= 1'b0;
            clear_pulse <= 1'b0;
        end else begin
            clear_pulse <= 1'b0;                      // one cycle only
            if (wr_fire) begin
                s_bvalid <= 1'b1;
                s_bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
                if (s_awaddr == REG_CTRL) begin
                    enable      <= s_wdata[CTRL_EN_BIT];
                    clear_pulse <= s_wdata[CTRL_CLR_BIT];
                end
            end else if (s_bvalid && s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_rvalid <= 1'b0;
            s_rresp  <= RESP_OKAY;
            s_rdata  <= '0;
        end else if (rd_fire) begin
            s_rvalid <= 1'b1;
            s_rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            s_rdata  <= rd_value;
        end else if (s_rvalid && s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frames_in_q  <= '0;
            frames_out_q <= '0;
        end else if (clear_pulse) begin
            frames_in_q  <= '0;
            frames_out_q <= '0;
        end else begin
            if (frame_in_pulse) begin
                frames_in_q <= frames_in_q + 1'b1;
            end
            if (frame_out_pulse) begin
                frames_out_q <= frames_out_q + 1'b1;
            end
        end
    end

endmodule

/* source/fb_pkg.sv */
package fb_pkg;

    // frame geometry, 32x32 image plus a one pixel border
    localparam int FRAME_DIM = 34;
    localparam int PIX_W     = 8;
    localparam int ROW_W     = FRAME_DIM * PIX_W;     // 272 bits per row
    localparam int IDX_W     = 6;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_DIM - 1);

    localparam int CNT_W = 32;                        // frame counters

    // register slave
    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL       = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS     = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_FRAMES_IN  = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_FRAMES_OUT = 4'hC;

    // ctrl bits
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;                  // self clearing

    // status bits
    localparam int STAT_FULL_LSB = 0;                 // bits 1:0
    localparam int STAT_WR_BANK  = 2;
    localparam int STAT_RD_BANK  = 3;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* source/frame_buffer_top.sv */
`timescale 1ns/100ps

module frame_buffer_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           pix_valid,
    output logic                           pix_ready,
    input  logic [fb_pkg::PIX_W-1:0]       pix_data,
    output logic                           row_valid,
    input  logic                           row_ready,
    output logic [fb_pkg::ROW_W-1:0]       row_data,
    output logic [fb_pkg::IDX_W-1:0]       row_index,
    output logic                           row_last,
    input  logic [fb_pkg::AXIL_ADDR_W-1:0] s_awaddr,
    input  logic                           s_awvalid,
    output logic                           s_awready,
    input  logic [fb_pkg::AXIL_DATA_W-1:0] s_wdata,
    input  logic                           s_wvalid,
    output logic                           s_wready,
    output logic [1:0]                     s_bresp,
    output logic                           s_bvalid,
    input  logic                           s_bready,
    input  logic [fb_pkg::AXIL_ADDR_W-1:0] s_araddr,
    input  logic                           s_arvalid,
    output logic                           s_arready,
    output logic [fb_pkg::AXIL_DATA_W-1:0] s_rdata,
    output logic [1:0]                     s_rresp,
    output logic                           s_rvalid,
    input  logic                           s_rready
);

    import fb_pkg::*;

    logic             wr_en;
    logic [IDX_W-1:0] wr_row;
    logic [IDX_W-1:0] wr_col;
    logic [PIX_W-1:0] wr_data;
    logic             wr_frame_end;
    logic             wr_full;
    logic             rd_avail;
    logic [ROW_W-1:0] rd_data;
    logic [IDX_W-1:0] rd_row;
    logic             rd_done;
    logic [1:0]       bank_full;
    logic             wr_bank;
    logic             rd_bank;
    logic             frame_in_pulse;
    logic             enable;
    logic             clear_pulse;

    // no pixel taken in the clear cycle
    assign pix_ready = enable & ~wr_full & ~clear_pulse;

    pixel_writer u_pixel_writer (
        .clk          (clk),
        .arst_n       (arst_n),
        .clear        (clear_pulse),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pix_data     (pix_data),
        .wr_en        (wr_en),
        .wr_row       (wr_row),
        .wr_col       (wr_col),
        .wr_data      (wr_data),
        .wr_frame_end (wr_frame_end)
    );

    pingpong_buffer u_pingpong_buffer (
        .clk            (clk),
        .arst_n         (arst_n),
        .clear          (clear_pulse),
        .wr_en          (wr_en),
        .wr_row         (wr_row),
        .wr_col         (wr_col),
        .wr_data        (wr_data),
        .wr_frame_end   (wr_frame_end),
        .rd_row         (rd_row),
        .rd_done        (rd_done),
        .wr_full        (wr_full),
        .rd_avail       (rd_avail),
        .rd_data        (rd_data),
        .bank_full      (bank_full),
        .wr_bank        (wr_bank),
        .rd_bank        (rd_bank),
        .frame_in_pulse (frame_in_pulse)
    );

    row_reader u_row_reader (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear_pulse),
        .rd_avail  (rd_avail),
        .rd_data   (rd_data),
        .row_ready (row_ready),
        .rd_row    (rd_row),
        .rd_done   (rd_done),
        .row_valid (row_valid),
        .row_data  (row_data),
        .row_index (row_index),
        .row_last  (row_last)
    );

    fb_ctrl_axil u_fb_ctrl_axil (
        .clk             (clk),
        .arst_n          (arst_n),
        .s_awaddr        (s_awaddr),
        .s_awvalid       (s_awvalid),
        .s_awready       (s_awready),
        .s_wdata         (s_wdata),
        .s_wvalid        (s_wvalid),
        .s_wready        (s_wready),
        .s_bresp         (s_bresp),
        .s_bvalid        (s_bvalid),
        .s_bready        (s_bready),
        .s_araddr        (s_araddr),
        .s_arvalid       (s_arvalid),
        .s_arready       (s_arready),
        .s_rdata         (s_rdata),
        .s_rresp         (s_rresp),
        .s_rvalid        (s_rvalid),
        .s_rready        (s_rready),
        .bank_full       (bank_full),
        .wr_bank         (wr_bank),
        .rd_bank         (rd_bank),
        .frame_in_pulse  (frame_in_pulse),
        .frame_out_pulse (rd_done),
        .enable          (enable),
        .clear_pulse     (clear_pulse)
    );

endmodule

/* source/pingpong_buffer.sv */
`timescale 1ns/100ps

module pingpong_buffer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     clear,
    input  logic                     wr_en,
    input  logic [fb_pkg::IDX_W-1:0] wr_row,
    input  logic [fb_pkg::IDX_W-1:0] wr_col,
    input  logic [fb_pkg::PIX_W-1:0] wr_data,
    input  logic                     wr_frame_end,
    input  logic [fb_pkg::IDX_W-1:0] rd_row,
    input  logic                     rd_done,
    output logic                     wr_full,
    output logic                     rd_avail,
    output logic [fb_pkg::ROW_W-1:0] rd_data,
    output logic [1:0]               bank_full,
    output logic                     wr_bank,
    output logic                     rd_bank,
    output logic                     frame_in_pulse
);

    import fb_pkg::*;

    // bank, row, column
    logic [PIX_W-1:0] mem [2][FRAME_DIM][FRAME_DIM];

    logic [1:0] full_q;
    logic       wr_bank_q;
    logic       rd_bank_q;

    always_ff @(posedge clk) begin
        if (wr_en && !clear) begin
            mem[wr_bank_q][wr_row][wr_col] <= wr_data;
        end
    end

    // whole row out, column 0 lands in the top byte
    always_comb begin
        for (int c = 0; c < FRAME_DIM; c++) begin
            rd_data[ROW_W-1-c*PIX_W -: PIX_W] = mem[rd_bank_q][rd_row][c];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q    <= 2'b00;
            wr_bank_q <= 1'b0;
            rd_bank_q <= 1'b0;
        end else if (clear) begin
            full_q    <= 2'b00;
            wr_bank_q <= 1'b0;
            rd_bank_q <= 1'b0;
        end else begin
            if (wr_frame_end) begin
                full_q[wr_bank_q] <= 1'b1;
                // move on at once, wr_full holds the writer off if still busy
                wr_bank_q         <= ~wr_bank_q;
            end
            if (rd_done) begin
                full_q[rd_bank_q] <= 1'b0;
                rd_bank_q         <= ~rd_bank_q;
            end
        end
    end

    assign wr_full        = full_q[wr_bank_q];        // other side not drained yet
    assign rd_avail       = full_q[rd_bank_q];
    assign bank_full      = full_q;
    assign wr_bank        = wr_bank_q;
    assign rd_bank        = rd_bank_q;
    assign frame_in_pulse = wr_frame_end & ~clear;

endmodule

/* source/pixel_writer.sv */
`timescale 1ns/100ps

module pixel_writer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     clear,
    input  logic                     pix_valid,
    input  logic                     pix_ready,
    input  logic [fb_pkg::PIX_W-1:0] pix_data,
    output logic                     wr_en,
    output logic [fb_pkg::IDX_W-1:0] wr_row,
    output logic [fb_pkg::IDX_W-1:0] wr_col,
    output logic [fb_pkg::PIX_W-1:0] wr_data,
    output logic                     wr_frame_end
);

    import fb_pkg::*;

    logic [IDX_W-1:0] col_q;
    logic [IDX_W-1:0] row_q;
    logic             col_wrap;
    logic             row_wrap;

    assign wr_en   = pix_valid & pix_ready;           // one write per transfer
    assign wr_row  = row_q;
    assign wr_col  = col_q;
    assign wr_data = pix_data;

    assign col_wrap = (col_q == LAST_IDX);
    assign row_wrap = (row_q == LAST_IDX);

    // last pixel of the frame, row 33 col 33
    assign wr_frame_end = wr_en & col_wrap & row_wrap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (clear) begin
            col_q <= '0;                              // drop partial frame
            row_q <= '0;
        end else if (wr_en) begin
            if (col_wrap) begin
                col_q <= '0;
                if (row_wrap) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

endmodule

/* source/row_reader.sv */
`timescale 1ns/100ps

module row_reader (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     clear,
    input  logic                     rd_avail,
    input  logic [fb_pkg::ROW_W-1:0] rd_data,
    input  logic                     row_ready,
    output logic [fb_pkg::IDX_W-1:0] rd_row,
    output logic                     rd_done,
    output logic                     row_valid,
    output logic [fb_pkg::ROW_W-1:0] row_data,
    output logic [fb_pkg::IDX_W-1:0] row_index,
    output logic                     row_last
);

    import fb_pkg::*;

    logic [IDX_W-1:0] next_row_q;                     // next row to fetch
    logic             all_loaded_q;                   // row 33 fetched, wait for rd_done
    logic             valid_q;
    logic [IDX_W-1:0] index_q;
    logic [ROW_W-1:0] data_q;
    logic             accept;
    logic             load;

    assign accept = valid_q & row_ready;
    assign load   = rd_avail & ~all_loaded_q & (~valid_q | row_ready);

    assign row_last = valid_q & (index_q == LAST_IDX);
    assign rd_done  = accept & row_last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            next_row_q   <= '0;
            all_loaded_q <= 1'b0;
            valid_q      <= 1'b0;
            index_q      <= '0;
        end else if (clear) begin
            next_row_q   <= '0;
            all_loaded_q <= 1'b0;
            valid_q      <= 1'b0;
            index_q      <= '0;
        end else begin
            if (load) begin
                valid_q <= 1'b1;
                index_q <= next_row_q;
                if (next_row_q == LAST_IDX) begin
                    next_row_q   <= '0;
                    all_loaded_q <= 1'b1;
                end else begin
                    next_row_q <= next_row_q + 1'b1;
                end
            end else if (accept) begin
                valid_q <= 1'b0;
            end
            if (rd_done) begin
                all_loaded_q <= 1'b0;                 // bank swaps on this edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= rd_data;
        end
    end

    assign rd_row    = next_row_q;
    assign row_valid = valid_q;
    assign row_data  = data_q;
    assign row_index = index_q;

endmodule
